//--- list.f
+incdir+.
mdio_frame_pkg.sv
mdio_ctrl_pkg.sv
mdio_cmd_decode.sv
mdio_frame_engine.sv
mdio_result.sv
mdio_master_top.sv
mdio_master_asserts.sv
tb_mdio_master.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mdio_master -f list.f
out=$(./obj_dir/Vtb_mdio_master)
echo "$out"
echo "$out" | grep -qx "Finished with no errors"

//--- tb_mdio_master.sv
`default_nettype none

`include "mdio_params.svh"

module tb_mdio_master;

    localparam int         DIV      = `MDIO_MDC_DIV;
    localparam logic [4:0] PHY_ADDR = 5'd5;        // Only address the PHY model answers
    localparam int         NUM_CMDS = 63;
    localparam int         TIMEOUT  = NUM_CMDS * (64 * 2 * DIV + 10) * 20 * 2;

    logic clk = 1'b0;
    logic resetn, req_i, mdio_i, ack_o, mdc_o, mdio_o, mdio_t_o;
    logic [4:0]  phy_addr_i, reg_addr_i;
    logic [15:0] wdata_i, rdata_o;
    mdio_frame_pkg::mdio_op_e op_i;

    logic [31:0] seed = 32'h5f15_fb9d;
    int          errors = 0, checks = 0, tests = 0, frames_seen = 0;
    logic [15:0] ref_regs [32];                    // Expected PHY register contents
    logic [15:0] phy_regs [32];

    // Fields the PHY model expects in the next frame
    mdio_frame_pkg::mdio_op_e exp_op;
    logic [4:0]  exp_phy, exp_reg;
    logic [15:0] exp_wdata;

    mdio_master_top u_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks = checks + 1;
        if (exp !== act) begin
            errors = errors + 1;
            $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests = tests + 1;
        $display("Test %0d %s: %0d mismatches", tests, name, errors - err0);
    endtask

    // One command through the whole req/ack cycle
    task automatic run_cmd(input mdio_frame_pkg::mdio_op_e op, input logic [4:0] pa,
                           input logic [4:0] ra, input logic [15:0] wd,
                           output logic [15:0] rd);
        int cycles;
        int frames0;
        exp_op    = op;
        exp_phy   = pa;
        exp_reg   = ra;
        exp_wdata = wd;
        frames0   = frames_seen;
        cycles    = 0;
        @(posedge clk);
        req_i      <= 1'b1;
        op_i       <= op;
        phy_addr_i <= pa;
        reg_addr_i <= ra;
        wdata_i    <= wd;
        do begin
            @(posedge clk);
            cycles = cycles + 1;
        end while (!ack_o);
        rd = rdata_o;
        check_value("req to ack cycles", 3 + 128 * DIV, cycles - 1);
        check_value("frames decoded", frames0 + 1, frames_seen);
        req_i <= 1'b0;
        do begin
            @(posedge clk);
        end while (ack_o);
    endtask

    ////////////////////////////////////////////////////////////
    // PHY model acting on MDC edges seen at clk rate
    ////////////////////////////////////////////////////////////

    logic        mdc_q = 1'b0;
    logic        drive = 1'b0;
    int          half_cnt = 0;
    int          ones = 0;
    int          pos = -1;                         // Bits after the preamble or -1 while hunting
    logic [31:0] fr;
    logic [15:0] tx;

    always @(posedge clk) begin
        if (resetn && mdc_o && !mdc_q) begin
            if (ones > 0 || pos >= 0)
                check_value("mdc low time", DIV, half_cnt);
            if (pos < 0 && mdio_o && !mdio_t_o) begin
                ones = ones + 1;
            end else if (pos < 0) begin
                check_value("preamble ones", `MDIO_PREAMBLE_LEN, ones);
                pos = 1;
                fr  = 32'(mdio_o);                 // First start bit
            end else begin
                // Reads release the bus from the first turnaround bit on
                check_value("mdio release",
                            32'(exp_op == mdio_frame_pkg::OP_READ && pos >= 14), mdio_t_o);
                fr  = {fr[30:0], mdio_t_o ? mdio_i : mdio_o};
                pos = pos + 1;
            end
            if (pos == 14) begin
                check_value("frame header", {2'b01, exp_op, exp_phy, exp_reg}, fr[13:0]);
                drive = (fr[11:10] == 2'b10) && (fr[9:5] == PHY_ADDR);
                tx    = phy_regs[fr[4:0]];
            end
            if (pos == 32 && fr[29:28] == 2'b01) begin
                check_value("write ta and data", {2'b10, exp_wdata}, fr[17:0]);
                if (fr[27:23] == PHY_ADDR)
                    phy_regs[fr[22:18]] = fr[15:0];
            end
            if (pos == 32) begin
                frames_seen <= frames_seen + 1;
                pos   = -1;
                ones  = 0;
                drive = 1'b0;
            end
        end else if (resetn && !mdc_o && mdc_q) begin
            check_value("mdc high time", DIV, half_cnt);
            if (drive && pos >= 16) begin
                mdio_i <= tx[15];                  // Read data MSB first
                tx = tx << 1;
            end else begin
                mdio_i <= !(drive && pos == 15);   // Pulled high except second TA bit
            end
        end
        half_cnt = (mdc_o != mdc_q) ? 1 : half_cnt + 1;
        mdc_q <= mdc_o;
    end

    initial begin
        logic [31:0]              r;
        logic [15:0]              rd;
        mdio_frame_pkg::mdio_op_e op;
        logic [4:0]               pa;
        int                       err0;

        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
            phy_regs[i] = '0;
        end
        resetn     = 1'b0;
        req_i      = 1'b0;
        op_i       = mdio_frame_pkg::OP_WRITE;
        phy_addr_i = '0;
        reg_addr_i = '0;
        wdata_i    = '0;
        mdio_i     = 1'b1;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);

        err0 = errors;
        check_value("reset outputs", 4'b0001, {ack_o, mdc_o, mdio_o, mdio_t_o});
        end_test("reset", err0);

        err0 = errors;
        r = next_rand();
        run_cmd(mdio_frame_pkg::OP_WRITE, PHY_ADDR, r[20:16], r[15:0], rd);
        ref_regs[r[20:16]] = r[15:0];
        run_cmd(mdio_frame_pkg::OP_READ, PHY_ADDR, r[20:16], 16'h0, rd);
        check_value("write then read", ref_regs[r[20:16]], rd);
        end_test("write_read", err0);

        err0 = errors;
        for (int i = 0; i < 60; i++) begin
            r  = next_rand();
            op = r[31] ? mdio_frame_pkg::OP_READ : mdio_frame_pkg::OP_WRITE;
            run_cmd(op, PHY_ADDR, r[20:16], r[15:0], rd);
            if (op == mdio_frame_pkg::OP_WRITE)
                ref_regs[r[20:16]] = r[15:0];
            else
                check_value("random read", ref_regs[r[20:16]], rd);
        end
        end_test("random", err0);

        // Nobody answers so the line stays pulled high
        err0 = errors;
        r  = next_rand();
        pa = (r[4:0] == PHY_ADDR) ? 5'd6 : r[4:0];
        run_cmd(mdio_frame_pkg::OP_READ, pa, r[20:16], 16'h0, rd);
        check_value("absent phy read", 16'hffff, rd);
        end_test("absent_phy", err0);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired after %0d time units, the DUT stopped answering", TIMEOUT);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- mdio_master_asserts.sv
`default_nettype none

module mdio_master_asserts (
    input wire                            clk,
    input wire                            resetn,
    input wire                            req_i,
    input wire                            ack_i,
    input wire                            mdio_t_i,
    input wire mdio_ctrl_pkg::eng_state_e eng_state_i
);

    // Ack only answers a request that is still held
    a_ack_after_req: assert property (@(posedge clk) disable iff (!resetn)
        $rose(ack_i) |-> req_i && $past(req_i))
        else $error("ack_o rose with no request pending");

    a_req_held: assert property (@(posedge clk) disable iff (!resetn)
        $fell(req_i) |-> $past(ack_i))
        else $error("req_i dropped before ack_o was seen");

    // Bus released while the engine is idle
    a_idle_release: assert property (@(posedge clk) disable iff (!resetn)
        eng_state_i == mdio_ctrl_pkg::IDLE |-> mdio_t_i)
        else $error("mdio_t_o low while the frame engine is idle");

endmodule

bind mdio_master_top mdio_master_asserts u_asserts (
    .clk         (clk),
    .resetn      (resetn),
    .req_i       (req_i),
    .ack_i       (ack_o),
    .mdio_t_i    (mdio_t_o),
    .eng_state_i (u_engine.state)
);

`default_nettype wire

//--- mdio_master_top.sv
`default_nettype none

`include "mdio_params.svh"

module mdio_master_top (
    input  wire                                  clk,
    input  wire                                  resetn,
    input  wire                                  req_i,
    input  wire mdio_frame_pkg::mdio_op_e        op_i,
    input  wire [mdio_frame_pkg::PHY_ADDR_W-1:0] phy_addr_i,
    input  wire [mdio_frame_pkg::REG_ADDR_W-1:0] reg_addr_i,
    input  wire [mdio_frame_pkg::DATA_W-1:0]     wdata_i,
    input  wire                                  mdio_i,
    output logic                                 ack_o,
    output logic [mdio_frame_pkg::DATA_W-1:0]    rdata_o,
    output logic                                 mdc_o,
    output logic                                 mdio_o,
    output logic                                 mdio_t_o      // High when released
);

    logic                              cmd_start;
    logic [`MDIO_FRAME_LEN-1:0]        frame_word;
    logic                              frame_is_read;
    logic                              frame_go;
    logic                              frame_done;
    logic [mdio_frame_pkg::DATA_W-1:0] rd_data;

    mdio_result u_result (
        .clk          (clk),
        .resetn       (resetn),
        .req_i        (req_i),
        .frame_done_i (frame_done),
        .rd_data_i    (rd_data),
        .cmd_start_o  (cmd_start),
        .ack_o        (ack_o),
        .rdata_o      (rdata_o)
    );

    mdio_cmd_decode u_decode (
        .clk             (clk),
        .resetn          (resetn),
        .cmd_start_i     (cmd_start),
        .op_i            (op_i),
        .phy_addr_i      (phy_addr_i),
        .reg_addr_i      (reg_addr_i),
        .wdata_i         (wdata_i),
        .frame_word_o    (frame_word),
        .frame_is_read_o (frame_is_read),
        .frame_go_o      (frame_go)
    );

    mdio_frame_engine u_engine (
        .clk             (clk),
        .resetn          (resetn),
        .frame_go_i      (frame_go),
        .frame_word_i    (frame_word),
        .frame_is_read_i (frame_is_read),
        .mdio_i          (mdio_i),
        .mdc_o           (mdc_o),
        .mdio_o          (mdio_o),
        .mdio_t_o        (mdio_t_o),
        .frame_done_o    (frame_done),
        .rd_data_o       (rd_data)
    );

endmodule

`default_nettype wire

//--- mdio_result.sv
`default_nettype none

module mdio_result (
    input  wire                                  clk,
    input  wire                                  resetn,
    input  wire                                  req_i,
    input  wire                                  frame_done_i,
    input  wire [mdio_frame_pkg::DATA_W-1:0]     rd_data_i,
    output logic                                 cmd_start_o,
    output logic                                 ack_o,
    output logic [mdio_frame_pkg::DATA_W-1:0]    rdata_o
);

    mdio_ctrl_pkg::hs_state_e state;

    ////////////////////////////////////////////////////////////
    // Four-phase req/ack handshake
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= mdio_ctrl_pkg::HS_IDLE;
            cmd_start_o <= 1'b0;
        end else begin
            cmd_start_o <= 1'b0;
            case (state)
                mdio_ctrl_pkg::HS_IDLE: begin
                    if (req_i) begin
                        cmd_start_o <= 1'b1;
                        state       <= mdio_ctrl_pkg::HS_BUSY;
                    end
                end
                mdio_ctrl_pkg::HS_BUSY: begin
                    if (frame_done_i)
                        state <= mdio_ctrl_pkg::HS_ACK;
                end
                mdio_ctrl_pkg::HS_ACK: begin
                    if (!req_i)
                        state <= mdio_ctrl_pkg::HS_IDLE;  // Host has seen ack
                end
                default: state <= mdio_ctrl_pkg::HS_IDLE;
            endcase
        end
    end

    // Read data held for the whole ack phase
    always_ff @(posedge clk) begin
        if (state == mdio_ctrl_pkg::HS_BUSY && frame_done_i)
            rdata_o <= rd_data_i;
    end

    assign ack_o = (state == mdio_ctrl_pkg::HS_ACK);

endmodule

`default_nettype wire

//--- mdio_frame_engine.sv
`default_nettype none

`include "mdio_params.svh"

module mdio_frame_engine (
    input  wire                                  clk,
    input  wire                                  resetn,
    input  wire                                  frame_go_i,
    input  wire [`MDIO_FRAME_LEN-1:0]            frame_word_i,
    input  wire                                  frame_is_read_i,
    input  wire                                  mdio_i,
    output logic                                 mdc_o,
    output logic                                 mdio_o,
    output logic                                 mdio_t_o,
    output logic                                 frame_done_o,
    output logic [mdio_frame_pkg::DATA_W-1:0]    rd_data_o
);

    localparam int DIV      = `MDIO_MDC_DIV;
    localparam int PRE      = `MDIO_PREAMBLE_LEN;
    localparam int TOTAL    = `MDIO_PREAMBLE_LEN + `MDIO_FRAME_LEN;
    localparam int DIV_W    = $clog2(DIV + 1);
    localparam int CNT_W    = $clog2(TOTAL + 1);
    localparam int REL_BIT  = PRE + mdio_frame_pkg::TA_POS;   // First released bit
    localparam int RD_FIRST = TOTAL - mdio_frame_pkg::DATA_W; // First PHY data bit

    mdio_ctrl_pkg::eng_state_e state;

    logic [DIV_W-1:0]                  div_cnt;
    logic [CNT_W-1:0]                  bit_cnt;
    logic [CNT_W-1:0]                  next_bit;
    logic                              half_end;
    logic [`MDIO_FRAME_LEN-1:0]        shift_q;
    logic                              is_read;
    logic [mdio_frame_pkg::DATA_W-1:0] rd_shift;

    assign half_end = (div_cnt == DIV_W'(DIV - 1));
    assign next_bit = bit_cnt + 1'b1;

    ////////////////////////////////////////////////////////////
    // MDC divider, bit counter and line drive
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= mdio_ctrl_pkg::IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            mdc_o    <= 1'b0;
            mdio_o   <= 1'b0;
            mdio_t_o <= 1'b1;
        end else begin
            case (state)
                mdio_ctrl_pkg::IDLE: begin
                    div_cnt  <= '0;
                    bit_cnt  <= '0;
                    mdc_o    <= 1'b0;
                    mdio_o   <= 1'b0;
                    mdio_t_o <= 1'b1;
                    if (frame_go_i) begin
                        state    <= mdio_ctrl_pkg::PREAMBLE;
                        mdio_o   <= 1'b1;       // First preamble bit
                        mdio_t_o <= 1'b0;
                    end
                end

                default: begin
                    if (half_end) begin
                        div_cnt <= '0;
                        mdc_o   <= ~mdc_o;
                        if (!mdc_o) begin
                            // Rising edge where the last bit hands over to FINISH
                            if (bit_cnt == CNT_W'(TOTAL - 1))
                                state <= mdio_ctrl_pkg::FINISH;
                        end else if (state == mdio_ctrl_pkg::FINISH) begin
                            state    <= mdio_ctrl_pkg::IDLE;
                            mdio_o   <= 1'b0;
                            mdio_t_o <= 1'b1;
                        end else begin
                            // Next bit goes out on the falling edge
                            bit_cnt <= next_bit;
                            if (next_bit >= CNT_W'(PRE)) begin
                                state    <= mdio_ctrl_pkg::SHIFT;
                                mdio_o   <= shift_q[`MDIO_FRAME_LEN-1];
                                mdio_t_o <= is_read && (next_bit >= CNT_W'(REL_BIT));
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame and read data shift registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == mdio_ctrl_pkg::IDLE && frame_go_i) begin
            shift_q <= frame_word_i;
            is_read <= frame_is_read_i;
        end else if ((state == mdio_ctrl_pkg::PREAMBLE || state == mdio_ctrl_pkg::SHIFT)
                     && half_end && mdc_o && next_bit >= CNT_W'(PRE)) begin
            shift_q <= shift_q << 1;
        end

        // Sample on the rising MDC edge of each data bit
        if (state == mdio_ctrl_pkg::SHIFT && is_read && half_end && !mdc_o
            && bit_cnt >= CNT_W'(RD_FIRST)) begin
            rd_shift <= {rd_shift[mdio_frame_pkg::DATA_W-2:0], mdio_i};
        end
    end

    // Last cycle of the final MDC high phase
    assign frame_done_o = (state == mdio_ctrl_pkg::FINISH) && half_end;
    assign rd_data_o    = rd_shift;

endmodule

`default_nettype wire

//--- mdio_cmd_decode.sv
`default_nettype none

`include "mdio_params.svh"

module mdio_cmd_decode (
    input  wire                                      clk,
    input  wire                                      resetn,
    input  wire                                      cmd_start_i,
    input  wire mdio_frame_pkg::mdio_op_e            op_i,
    input  wire [mdio_frame_pkg::PHY_ADDR_W-1:0]     phy_addr_i,
    input  wire [mdio_frame_pkg::REG_ADDR_W-1:0]     reg_addr_i,
    input  wire [mdio_frame_pkg::DATA_W-1:0]         wdata_i,
    output logic [`MDIO_FRAME_LEN-1:0]               frame_word_o,
    output logic                                     frame_is_read_o,
    output logic                                     frame_go_o
);

    logic                              is_read;
    logic [1:0]                        ta_bits;
    logic [mdio_frame_pkg::DATA_W-1:0] data_bits;

    // Reads leave turnaround and data to the PHY
    assign is_read   = (op_i == mdio_frame_pkg::OP_READ);
    assign ta_bits   = is_read ? 2'b00 : mdio_frame_pkg::TA_WRITE;
    assign data_bits = is_read ? '0 : wdata_i;

    ////////////////////////////////////////////////////////////
    // Frame word with the MSB sent first
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cmd_start_i) begin
            frame_word_o    <= {mdio_frame_pkg::START_BITS,
                                op_i,
                                phy_addr_i,
                                reg_addr_i,
                                ta_bits,
                                data_bits};
            frame_is_read_o <= is_read;
        end
    end

    // Go follows the latch by one cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            frame_go_o <= 1'b0;
        end else begin
            frame_go_o <= cmd_start_i;
        end
    end

endmodule

`default_nettype wire

//--- mdio_ctrl_pkg.sv
`default_nettype none

package mdio_ctrl_pkg;

    // Frame engine
    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE,
        SHIFT,
        FINISH
    } eng_state_e;

    // Host handshake
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_BUSY,
        HS_ACK
    } hs_state_e;

endpackage

`default_nettype wire

//--- mdio_frame_pkg.sv
`default_nettype none

package mdio_frame_pkg;

    ////////////////////////////////////////////////////////////
    // Clause-22 frame fields
    ////////////////////////////////////////////////////////////

    // Opcode as sent on the wire
    typedef enum logic [1:0] {
        OP_WRITE = 2'b01,
        OP_READ  = 2'b10
    } mdio_op_e;

    localparam int PHY_ADDR_W = 5;
    localparam int REG_ADDR_W = 5;
    localparam int DATA_W     = 16;

    localparam logic [1:0] START_BITS = 2'b01;  // Clause-22 start
    localparam logic [1:0] TA_WRITE   = 2'b10;  // Master keeps driving on writes

    // Bit index of the first turnaround bit, counted after the preamble
    localparam int TA_POS = $bits(START_BITS) + $bits(mdio_op_e)
                          + PHY_ADDR_W + REG_ADDR_W;

endpackage

`default_nettype wire

//--- mdio_params.svh
`ifndef MDIO_PARAMS_SVH
`define MDIO_PARAMS_SVH

////////////////////////////////////////////////////////////
// MDC clock divider
////////////////////////////////////////////////////////////

// clk cycles per MDC half period
`define MDIO_MDC_DIV 4

////////////////////////////////////////////////////////////
// Clause-22 frame lengths, in MDC periods
////////////////////////////////////////////////////////////

// Ones sent ahead of the start bits
`define MDIO_PREAMBLE_LEN 32

// Start, opcode, addresses, turnaround and data
`define MDIO_FRAME_LEN 32

`endif
